//--- design/mipsPkg.sv
package mipsPkg;

	localparam int dataWidth = 32; // word and address width.
	localparam int regAddrWidth = 5;
	localparam int dataMemWords = 16; // words of data memory.
	localparam int linkAddr = 31; // JAL return register.

	typedef enum logic [5:0] {
		RType = 6'h00,
		J = 6'h02,
		Jal = 6'h03,
		Beq = 6'h04,
		Bne = 6'h05,
		Addi = 6'h08,
		Ori = 6'h0d,
		Lui = 6'h0f,
		Lw = 6'h23,
		Sw = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		Sll = 6'h00,
		Srl = 6'h02,
		Jr = 6'h08,
		Add = 6'h20,
		Sub = 6'h22,
		AndF = 6'h24,
		OrF = 6'h25,
		Slt = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluSlt,
		AluSll,
		AluSrl,
		AluLui
	} aluOpT;

	// four-phase handshake states.
	typedef enum logic [1:0] {
		Idle,
		Req,
		WaitAckLow
	} linkStateT;

endpackage

//--- design/aluUnit.sv
module aluUnit (
	input mipsPkg::aluOpT aluOp,
	input logic [mipsPkg::dataWidth-1:0] a,
	input logic [mipsPkg::dataWidth-1:0] b,
	input logic [4:0] shamt,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic zero
);

	always_comb begin
		case (aluOp)
			mipsPkg::AluAdd: result = a + b;
			mipsPkg::AluSub: result = a - b;
			mipsPkg::AluAnd: result = a & b;
			mipsPkg::AluOr: result = a | b;
			mipsPkg::AluSlt: begin
				result = '0;
				result[0] = $signed(a) < $signed(b); // signed compare.
			end
			mipsPkg::AluSll: result = b << shamt;
			mipsPkg::AluSrl: result = b >> shamt;
			mipsPkg::AluLui: result = b << 16;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // used by BEQ and BNE.

endmodule

//--- design/control.sv
module control (
	input mipsPkg::opcodeT opcode,
	input mipsPkg::functT funct,
	output logic regDst,
	output logic aluSrc,
	output logic memToReg,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branchEq,
	output logic branchNe,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output logic shamtSel,
	output mipsPkg::aluOpT aluOp
);

	always_comb begin
		regDst = 1'b0;
		aluSrc = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		link = 1'b0;
		shamtSel = 1'b0;
		aluOp = mipsPkg::AluAdd;
		case (opcode)
			mipsPkg::RType: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					mipsPkg::Add: aluOp = mipsPkg::AluAdd;
					mipsPkg::Sub: aluOp = mipsPkg::AluSub;
					mipsPkg::AndF: aluOp = mipsPkg::AluAnd;
					mipsPkg::OrF: aluOp = mipsPkg::AluOr;
					mipsPkg::Slt: aluOp = mipsPkg::AluSlt;
					mipsPkg::Sll: begin
						aluOp = mipsPkg::AluSll;
						shamtSel = 1'b1;
					end
					mipsPkg::Srl: begin
						aluOp = mipsPkg::AluSrl;
						shamtSel = 1'b1;
					end
					mipsPkg::Jr: begin
						regDst = 1'b0;
						regWrite = 1'b0;
						jumpReg = 1'b1;
					end
					default: begin
						regDst = 1'b0; // unknown funct is a nop.
						regWrite = 1'b0;
					end
				endcase
			end
			mipsPkg::Addi: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::Ori: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				aluOp = mipsPkg::AluOr;
			end
			mipsPkg::Lui: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				aluOp = mipsPkg::AluLui;
			end
			mipsPkg::Lw: begin
				aluSrc = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			mipsPkg::Sw: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::Beq: begin
				branchEq = 1'b1;
				aluOp = mipsPkg::AluSub;
			end
			mipsPkg::Bne: begin
				branchNe = 1'b1;
				aluOp = mipsPkg::AluSub;
			end
			mipsPkg::J: jump = 1'b1;
			mipsPkg::Jal: begin
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
			end
			default: ; // everything stays inactive.
		endcase
	end

endmodule

//--- design/instrFetch.sv
module instrFetch (
	input logic clk,
	input logic rst,
	output logic [mipsPkg::dataWidth-1:0] imemAddr,
	input logic [mipsPkg::dataWidth-1:0] imemData,
	output logic fetchReq,
	output logic [mipsPkg::dataWidth-1:0] fetchInstr,
	output logic [mipsPkg::dataWidth-1:0] fetchPc,
	input logic fetchAck,
	input logic redirect,
	input logic [mipsPkg::dataWidth-1:0] redirectPc
);

	mipsPkg::linkStateT state;
	logic [mipsPkg::dataWidth-1:0] pc;
	logic dataValid; // imemData reflects the current pc.

	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mipsPkg::Idle;
			pc <= '0;
			fetchReq <= 1'b0;
			dataValid <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc; // drop any word in flight.
			fetchReq <= 1'b0;
			dataValid <= 1'b0;
			state <= mipsPkg::Idle;
		end else begin
			case (state)
				mipsPkg::Idle: begin
					if (dataValid) begin
						fetchInstr <= imemData;
						fetchPc <= pc;
						fetchReq <= 1'b1;
						state <= mipsPkg::Req;
					end else begin
						dataValid <= 1'b1; // memory answers next cycle.
					end
				end
				mipsPkg::Req: begin
					if (fetchAck) begin
						fetchReq <= 1'b0;
						pc <= pc + mipsPkg::dataWidth'(4);
						dataValid <= 1'b0;
						state <= mipsPkg::WaitAckLow;
					end
				end
				mipsPkg::WaitAckLow: begin
					if (!fetchAck) state <= mipsPkg::Idle;
				end
				default: state <= mipsPkg::Idle;
			endcase
		end
	end

endmodule

//--- design/instrQueue.sv
module instrQueue #(
	parameter int depth = 4
) (
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input logic [mipsPkg::dataWidth-1:0] fetchInstr,
	input logic [mipsPkg::dataWidth-1:0] fetchPc,
	output logic fetchAck,
	output logic issueReq,
	output logic [mipsPkg::dataWidth-1:0] issueInstr,
	output logic [mipsPkg::dataWidth-1:0] issuePc,
	input logic issueAck,
	input logic redirect
);

	logic [mipsPkg::dataWidth-1:0] instrMem [depth];
	logic [mipsPkg::dataWidth-1:0] pcMem [depth];
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth+1)-1:0] count;
	logic push;
	logic pop;

	// no ack while full, so fetch stalls.
	assign push = fetchReq && !fetchAck && (count != depth) && !redirect;
	assign pop = issueReq && issueAck;

	always_ff @(posedge clk) begin
		if (push) begin
			instrMem[wrPtr] <= fetchInstr;
			pcMem[wrPtr] <= fetchPc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			fetchAck <= 1'b0;
			issueReq <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
				fetchAck <= 1'b1;
			end else if (fetchAck && !fetchReq) begin
				fetchAck <= 1'b0;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
				issueReq <= 1'b0;
			end else if (!issueReq && !issueAck && count != '0) begin
				issueInstr <= instrMem[rdPtr]; // head entry.
				issuePc <= pcMem[rdPtr];
				issueReq <= 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/execStage.sv
module execStage (
	input logic clk,
	input logic rst,
	input logic issueReq,
	input logic [mipsPkg::dataWidth-1:0] issueInstr,
	input logic [mipsPkg::dataWidth-1:0] issuePc,
	output logic issueAck,
	output logic redirect,
	output logic [mipsPkg::dataWidth-1:0] redirectPc,
	output logic wbValid,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0] wbData,
	output logic storeValid,
	output logic [mipsPkg::dataWidth-1:0] storeAddr,
	output logic [mipsPkg::dataWidth-1:0] storeData
);

	mipsPkg::linkStateT state;
	mipsPkg::aluOpT aluOp;
	logic [mipsPkg::dataWidth-1:0] regFile [2**mipsPkg::regAddrWidth];
	logic [mipsPkg::dataWidth-1:0] dataMem [mipsPkg::dataMemWords];
	logic regDst, aluSrc, memToReg, regWrite, memRead, memWrite;
	logic branchEq, branchNe, jump, jumpReg, link, shamtSel, zero;
	logic [mipsPkg::dataWidth-1:0] rsData, rtData, immExt, aluB, aluResult;
	logic [mipsPkg::dataWidth-1:0] pcPlus4, loadData, wbValue, target;
	logic [mipsPkg::regAddrWidth-1:0] writeReg;
	logic [$clog2(mipsPkg::dataMemWords)-1:0] memIdx;
	logic [15:0] imm;
	logic doExec, taken, doWrite;

	control ctrl (
		.opcode(mipsPkg::opcodeT'(issueInstr[31:26])), .funct(mipsPkg::functT'(issueInstr[5:0])),
		.regDst, .aluSrc, .memToReg, .regWrite, .memRead, .memWrite, .branchEq, .branchNe,
		.jump, .jumpReg, .link, .shamtSel, .aluOp
	);

	aluUnit alu (
		.aluOp, .a(rsData), .b(aluB), .shamt(shamtSel ? issueInstr[10:6] : 5'd0),
		.result(aluResult), .zero
	);

	assign imm = issueInstr[15:0];
	assign rsData = regFile[issueInstr[25:21]];
	assign rtData = regFile[issueInstr[20:16]];
	// ORI takes a zero-extended immediate.
	assign immExt = (aluOp == mipsPkg::AluOr) ? {16'b0, imm} : {{16{imm[15]}}, imm};
	assign aluB = aluSrc ? immExt : rtData;
	assign pcPlus4 = issuePc + mipsPkg::dataWidth'(4);
	assign memIdx = aluResult[$clog2(mipsPkg::dataMemWords)+1:2]; // word address mod size.
	assign loadData = memRead ? dataMem[memIdx] : '0;
	assign writeReg = link ? mipsPkg::regAddrWidth'(mipsPkg::linkAddr)
		: (regDst ? issueInstr[15:11] : issueInstr[20:16]);
	assign wbValue = link ? pcPlus4 : (memToReg ? loadData : aluResult);
	assign taken = (branchEq && zero) || (branchNe && !zero);
	assign doExec = (state == mipsPkg::Idle) && issueReq;
	assign doWrite = doExec && regWrite && (writeReg != '0);

	always_comb begin
		if (jumpReg) target = rsData;
		else if (jump) target = {pcPlus4[31:28], issueInstr[25:0], 2'b00};
		else target = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) regFile[i] <= '0;
			for (int i = 0; i < mipsPkg::dataMemWords; i++) dataMem[i] <= '0;
		end else begin
			if (doWrite) regFile[writeReg] <= wbValue;
			if (doExec && memWrite) dataMem[memIdx] <= rtData;
		end
	end

	always_ff @(posedge clk) begin
		if (doExec) begin
			redirectPc <= target;
			wbReg <= writeReg;
			wbData <= wbValue;
			storeAddr <= aluResult;
			storeData <= rtData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mipsPkg::Idle;
			issueAck <= 1'b0;
			redirect <= 1'b0;
			wbValid <= 1'b0;
			storeValid <= 1'b0;
		end else begin
			redirect <= 1'b0; // one-cycle pulses.
			wbValid <= 1'b0;
			storeValid <= 1'b0;
			case (state)
				mipsPkg::Idle: begin
					if (issueReq) begin
						issueAck <= 1'b1;
						redirect <= taken || jump || jumpReg;
						wbValid <= doWrite;
						storeValid <= memWrite;
						state <= mipsPkg::Req;
					end
				end
				mipsPkg::Req: begin
					if (!issueReq) begin
						issueAck <= 1'b0; // queue may offer the next word.
						state <= mipsPkg::Idle;
					end
				end
				default: state <= mipsPkg::Idle;
			endcase
		end
	end

endmodule

//--- design/mipsCore.sv
module mipsCore (
	input logic clk,
	input logic rst,
	output logic [mipsPkg::dataWidth-1:0] imemAddr,
	input logic [mipsPkg::dataWidth-1:0] imemData,
	output logic wbValid,
	output logic [mipsPkg::regAddrWidth-1:0] wbReg,
	output logic [mipsPkg::dataWidth-1:0] wbData,
	output logic storeValid,
	output logic [mipsPkg::dataWidth-1:0] storeAddr,
	output logic [mipsPkg::dataWidth-1:0] storeData
);

	logic fetchReq, fetchAck, issueReq, issueAck, redirect;
	logic [mipsPkg::dataWidth-1:0] fetchInstr, fetchPc;
	logic [mipsPkg::dataWidth-1:0] issueInstr, issuePc, redirectPc;

	instrFetch fetch (
		.clk, .rst, .imemAddr, .imemData, .fetchReq, .fetchInstr, .fetchPc, .fetchAck,
		.redirect, .redirectPc
	);

	// four words between fetch and execute.
	instrQueue #(.depth(4)) queue (
		.clk, .rst, .fetchReq, .fetchInstr, .fetchPc, .fetchAck, .issueReq, .issueInstr,
		.issuePc, .issueAck, .redirect
	);

	execStage exec (
		.clk, .rst, .issueReq, .issueInstr, .issuePc, .issueAck, .redirect, .redirectPc,
		.wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
	);

endmodule

//--- sim/mipsCore_chk.sv
module mipsCore_chk #(
	parameter int depth = 4
) (
	input logic clk,
	input logic rst,
	input logic redirect,
	input logic fetchReq,
	input logic fetchAck,
	input logic issueReq,
	input logic issueAck,
	input logic [$clog2(depth+1)-1:0] count
);

	// a request holds until its ack, unless a redirect cancels it.
	fetchReqHeld: assert property (@(posedge clk) disable iff (rst)
		fetchReq && !fetchAck && !redirect |=> fetchReq)
		else $error("fetchReq dropped before fetchAck");

	issueReqHeld: assert property (@(posedge clk) disable iff (rst)
		issueReq && !issueAck && !redirect |=> issueReq)
		else $error("issueReq dropped before issueAck");

	fetchAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(fetchAck) |-> fetchReq)
		else $error("fetchAck rose without fetchReq");

	issueAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
		$rose(issueAck) |-> issueReq)
		else $error("issueAck rose without issueReq");

	noAckWhenFull: assert property (@(posedge clk) disable iff (rst)
		(count == depth) && !fetchAck |=> !fetchAck)
		else $error("fetchAck rose while the queue was full");

	resetLinksLow: assert property (@(posedge clk)
		rst |=> !fetchReq && !fetchAck && !issueReq && !issueAck)
		else $error("a link was active during reset");

endmodule

bind instrQueue mipsCore_chk #(.depth(depth)) chk_i (
	.clk, .rst, .redirect, .fetchReq, .fetchAck, .issueReq, .issueAck, .count
);

//--- sim/mipsCore_tb.sv
module mipsCore_tb;

	localparam int traceWords = 256;
	localparam int drainCycles = 40; // quiet window after the last record.

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [mipsPkg::dataWidth-1:0] imemAddr;
	logic [mipsPkg::dataWidth-1:0] imemData = '0;
	logic wbValid;
	logic [mipsPkg::regAddrWidth-1:0] wbReg;
	logic [mipsPkg::dataWidth-1:0] wbData;
	logic storeValid;
	logic [mipsPkg::dataWidth-1:0] storeAddr;
	logic [mipsPkg::dataWidth-1:0] storeData;

	logic [31:0] trace [traceWords];
	string testNames [6] = '{"reset", "arithmetic", "memory", "branches", "jumps", "queue flush"};
	int progWords = 0;
	int recCount = 0;
	int recIdx = 0;
	int cycles = 0;
	int cycleLimit = 0;
	int errors = 0;
	int testErrors = 0;
	int testRecs = 0;
	int testsOk = 0;
	int testsBad = 0;

	mipsCore dut_i (
		.clk, .rst, .imemAddr, .imemData, .wbValid, .wbReg, .wbData,
		.storeValid, .storeAddr, .storeData
	);

	always #50 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	// memory answers one cycle after the address.
	always @(posedge clk) imemData <= progWord(imemAddr);

	function automatic logic [31:0] progWord(input logic [31:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < progWords) return trace[2 + idx];
		return '0; // nop past the program.
	endfunction

	// each record is three words after the counts and the program.
	function automatic int recBase(input int idx);
		return 2 + progWords + 3 * idx;
	endfunction

	task automatic noteError();
		errors++;
		testErrors++;
	endtask

	task automatic takeRecord(input int kind, input string what, output bit ok);
		int base;
		base = recBase(recIdx);
		ok = 1'b0;
		if (recIdx >= recCount) begin
			$display("Error: unexpected %s after the last expected record", what);
			errors++;
		end else if (int'(trace[base][3:0]) != kind) begin
			$display("Error: a %s arrived where test %0d expects another record", what,
				trace[base][7:4]);
			noteError();
		end else begin
			ok = 1'b1;
		end
	endtask

	task automatic closeRecord();
		int test;
		test = int'(trace[recBase(recIdx)][7:4]);
		testRecs++;
		recIdx++;
		if (recIdx == recCount || int'(trace[recBase(recIdx)][7:4]) != test) begin
			$display("Test %0d (%s): %0d records, %0d errors", test, testNames[test - 1],
				testRecs, testErrors);
			if (testErrors == 0) testsOk++;
			else testsBad++;
			testErrors = 0;
			testRecs = 0;
		end
	endtask

	task automatic checkWrite(
		input logic [mipsPkg::regAddrWidth-1:0] gotReg,
		input logic [mipsPkg::dataWidth-1:0] gotData,
		input logic [mipsPkg::regAddrWidth-1:0] expReg,
		input logic [mipsPkg::dataWidth-1:0] expData
	);
		if (gotReg !== expReg) begin
			$display("Fail wbReg: got %h, expected %h", gotReg, expReg);
			noteError();
		end
		if (gotData !== expData) begin
			$display("Fail wbData: got %h, expected %h", gotData, expData);
			noteError();
		end
	endtask

	task automatic checkStore(
		input logic [mipsPkg::dataWidth-1:0] gotAddr,
		input logic [mipsPkg::dataWidth-1:0] gotData,
		input logic [mipsPkg::dataWidth-1:0] expAddr,
		input logic [mipsPkg::dataWidth-1:0] expData
	);
		if (gotAddr !== expAddr) begin
			$display("Fail storeAddr: got %h, expected %h", gotAddr, expAddr);
			noteError();
		end
		if (gotData !== expData) begin
			$display("Fail storeData: got %h, expected %h", gotData, expData);
			noteError();
		end
	endtask

	// outputs are settled at the falling edge.
	always @(negedge clk) begin : watch
		bit ok;
		int base;
		if (rst) begin
			if (wbValid === 1'b1 || storeValid === 1'b1) begin
				$display("Error: a write or store pulse appeared during reset");
				errors++;
			end
		end else begin
			base = recBase(recIdx);
			if (wbValid) begin
				takeRecord(1, "register write", ok);
				if (ok) checkWrite(wbReg, wbData, trace[base + 1][mipsPkg::regAddrWidth-1:0],
					trace[base + 2]);
				if (recIdx < recCount) closeRecord();
			end
			if (storeValid) begin
				takeRecord(2, "store", ok);
				if (ok) checkStore(storeAddr, storeData, trace[base + 1], trace[base + 2]);
				if (recIdx < recCount) closeRecord();
			end
		end
	end

	initial begin
		$readmemh("sim/mipsCore_trace.txt", trace);
		progWords = int'(trace[0]);
		recCount = int'(trace[1]);
		cycleLimit = 12 * progWords + 100;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		while (recIdx < recCount && cycles < cycleLimit) @(posedge clk);
		if (recIdx < recCount) begin
			$display("Timeout: the program did not finish within %0d cycles", cycleLimit);
			errors++;
		end else begin
			repeat (drainCycles) @(posedge clk); // stray records show up here.
		end
		$display("Summary: %0d tests ok, %0d tests failed, %0d errors", testsOk, testsBad, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- sim/mipsCore_trace.txt
// first line: program word count, record count; then program words from address 0.
// records: tag (test number, kind 1 write 2 store), register or address, value.
31 1c
20010005 20020003 00221820 00222022 00222824 00223025 0041382a 00014100
00084882 342af0f0 3c0b1234 ac0a0008 ac03001c 8c0c0008 8c0d005c 10220001
200e0001 14220001 200e0063 106d0002 200f0001 200f0002 14a70001 200f0033
0c000020 20110011 08000022 20100066 00000000 00000000 00000000 00000000
20100044 03e00008 20120001 22530001 22740001 22950001 22b60001 22d70001
0800002e 20180077 20180077 20180077 20180077 20180077 22f90010 ac190030
08000030
11 01 00000005
21 02 00000003 21 03 00000008 21 04 00000002 21 05 00000001
21 06 00000007 21 07 00000001 21 08 00000050 21 09 00000014
21 0a 0000f0f5 21 0b 12340000
32 08 0000f0f5 32 1c 00000008 31 0c 0000f0f5 31 0d 00000008
41 0e 00000001 41 0f 00000033
51 1f 00000064 51 10 00000044 51 11 00000011
61 12 00000001 61 13 00000002 61 14 00000003 61 15 00000004
61 16 00000005 61 17 00000006 61 19 00000016 62 30 00000016

//--- sim.f
design/mipsPkg.sv
design/aluUnit.sv
design/control.sv
design/instrFetch.sv
design/instrQueue.sv
design/execStage.sv
design/mipsCore.sv
sim/mipsCore_chk.sv
sim/mipsCore_tb.sv

//--- Makefile
top = mipsCore_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(top) -f sim.f

obj_dir/V$(top): sim.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module $(top) -f sim.f

sim: obj_dir/V$(top)
	@out=$$(./obj_dir/V$(top)); echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
